// ==== f2x_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "float_to_fixed_defs.svh"

module f2x_align (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   en,
    input  fixed_fmt_pkg::stage1_t s1,
    output fixed_fmt_pkg::stage2_t s2
);
    import float_fmt_pkg::*;
    import fixed_fmt_pkg::*;

    localparam int INT_W    = `F2X_INT_WID;
    localparam int FRA_W    = `F2X_FRA_WID;
    localparam int MANT_W   = `F2X_MANT_WID;
    localparam int COARSE_W = `F2X_COARSE_WID;
    localparam int MS_W     = MANT_W + (1 << COARSE_W);
    // top in-range bit sits at MANT_W + 31
    localparam int FULL_W   = MANT_W + INT_W + FRA_W;

    logic [FULL_W-1:0] mant_ext;
    logic [FULL_W-1:0] mant_full;
    result_act_e       act;

    assign mant_ext  = {{(FULL_W-MS_W){1'b0}}, s1.mant};
    assign mant_full = mant_ext << {s1.fine_shift, {COARSE_W{1'b0}}};    // steps of 8

    always_comb begin
        if ((s1.cls == fc_zero) || (s1.cls == fc_nan) || (s1.cls == fc_denorm)
            || s1.underflow) begin
            act = act_clear;
        end else if ((s1.cls == fc_inf) || s1.overflow || s1.exact_min) begin
            act = act_saturate;
        end else begin
            act = act_pass;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s2 <= '0;
        end else if (en) begin
            s2.sign      <= s1.sign;
            s2.cls       <= s1.cls;
            s2.overflow  <= s1.overflow;
            s2.underflow <= s1.underflow;
            s2.act       <= act;
            // 15 int, 16 fraction, 1 round bit below the mantissa lsb position
            s2.window    <= {1'b0, mant_full[MANT_W +: INT_W + FRA_W]};
        end
    end

endmodule

`default_nettype wire

// ==== f2x_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "float_to_fixed_defs.svh"

module f2x_classify (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       en,
    input  float_fmt_pkg::float_word_t float_val,
    output fixed_fmt_pkg::stage1_t     s1
);
    import float_fmt_pkg::*;

    localparam int EXP_W    = `F2X_EXP_WID;
    localparam int MANT_W   = `F2X_MANT_WID;
    localparam int SHIFT_W  = `F2X_SHIFT_WID;
    localparam int COARSE_W = `F2X_COARSE_WID;
    localparam int MS_W     = MANT_W + (1 << COARSE_W);

    // largest exponent that still fits 15 magnitude bits
    localparam logic [EXP_W-1:0] EXP_UPPER = EXP_W'(`F2X_EXP_BIAS + `F2X_INT_WID - 2);
    // below this even the round bit is gone
    localparam logic [EXP_W-1:0] EXP_LOWER = EXP_W'(`F2X_EXP_BIAS - `F2X_FRA_WID - 1);
    localparam logic [EXP_W-1:0] EXP_MIN   = EXP_W'(`F2X_EXP_BIAS + `F2X_INT_WID - 1);

    // -2^15, the one pattern above EXP_UPPER that is representable
    localparam float_word_t MIN_WORD = '{sign: 1'b1, exponent: EXP_MIN, mantissa: '0};

    float_class_e       cls;
    logic [EXP_W-1:0]   shift_full;
    logic [SHIFT_W-1:0] shift_amt;
    logic               above_range;

    always_comb begin
        if (float_val.exponent == '0) begin
            cls = (float_val.mantissa == '0) ? fc_zero : fc_denorm;
        end else if (float_val.exponent == '1) begin
            cls = (float_val.mantissa == '0) ? fc_inf : fc_nan;
        end else begin
            cls = fc_normal;
        end
    end

    assign shift_full  = float_val.exponent - EXP_LOWER;    // exp - bias + 17
    assign shift_amt   = shift_full[SHIFT_W-1:0];
    assign above_range = float_val.exponent > EXP_UPPER;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1 <= '0;
        end else if (en) begin
            s1.sign       <= float_val.sign;
            s1.cls        <= cls;
            s1.overflow   <= above_range && (float_val != MIN_WORD);
            s1.underflow  <= float_val.exponent < EXP_LOWER;
            s1.exact_min  <= float_val == MIN_WORD;
            s1.fine_shift <= shift_amt[SHIFT_W-1:COARSE_W];
            // hidden one restored, low shift bits applied here
            s1.mant       <= {{(MS_W-MANT_W-1){1'b0}}, 1'b1, float_val.mantissa}
                             << shift_amt[COARSE_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== f2x_round.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "float_to_fixed_defs.svh"

module f2x_round (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   en,
    input  fixed_fmt_pkg::stage2_t s2,
    output fixed_fmt_pkg::stage4_t s4
);
    import fixed_fmt_pkg::*;

    localparam int INT_W = `F2X_INT_WID;
    localparam int FRA_W = `F2X_FRA_WID;
    localparam int Q_W   = `F2X_FRA_WID / 4;    // low quarter of the fraction
    localparam int WIN_W = INT_W + FRA_W + 1;
    localparam int HI_W  = FRA_W - Q_W;

    stage2_t          s3;
    logic [Q_W:0]     low_sum;
    logic [HI_W:0]    high_sum;
    logic [INT_W-1:0] int_sum;

    // round bit into the low quarter
    assign low_sum = {1'b0, s2.window[1 +: Q_W]} + {{Q_W{1'b0}}, s2.window[0]};

    // stage 3, window now holds upper bits, carry, rounded low quarter
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s3 <= '0;
        end else if (en) begin
            s3        <= s2;
            s3.window <= {s2.window[WIN_W-1:Q_W+1], low_sum};
        end
    end

    assign high_sum = {1'b0, s3.window[FRA_W:Q_W+1]} + {{HI_W{1'b0}}, s3.window[Q_W]};
    assign int_sum  = s3.window[WIN_W-1:FRA_W+1] + {{(INT_W-1){1'b0}}, high_sum[HI_W]};

    // stage 4
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s4 <= '0;
        end else if (en) begin
            s4.sign         <= s3.sign;
            s4.cls          <= s3.cls;
            s4.overflow     <= s3.overflow;
            s4.underflow    <= s3.underflow;
            s4.act          <= s3.act;
            s4.mag.int_part <= int_sum;    // may reach bit 15 on carry
            s4.mag.fra_part <= {high_sum[HI_W-1:0], s3.window[Q_W-1:0]};
        end
    end

endmodule

`default_nettype wire

// ==== f2x_sign_sat.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "float_to_fixed_defs.svh"

module f2x_sign_sat (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      en,
    input  fixed_fmt_pkg::stage4_t    s4,
    output fixed_fmt_pkg::fix_value_t fixed_value,
    output fixed_fmt_pkg::fix_flags_t flags
);
    import float_fmt_pkg::*;
    import fixed_fmt_pkg::*;

    localparam int INT_W = `F2X_INT_WID;
    localparam int FRA_W = `F2X_FRA_WID;

    localparam fix_value_t MAX_VAL = '{
        int_part: {1'b0, {(INT_W-1){1'b1}}},
        fra_part: {FRA_W{1'b1}}
    };
    localparam fix_value_t MIN_VAL = '{
        int_part: {1'b1, {(INT_W-1){1'b0}}},
        fra_part: {FRA_W{1'b0}}
    };

    logic [FRA_W:0]   fra_neg;
    logic [INT_W-1:0] int_neg;
    fix_value_t       signed_val;
    logic             no_range;

    // two's complement, carry out of the fraction only when it is zero
    assign fra_neg = {1'b0, ~s4.mag.fra_part} + {{FRA_W{1'b0}}, 1'b1};
    assign int_neg = ~s4.mag.int_part + {{(INT_W-1){1'b0}}, fra_neg[FRA_W]};

    assign signed_val = s4.sign ? {int_neg, fra_neg[FRA_W-1:0]} : s4.mag;
    assign no_range   = (s4.cls == fc_zero) || (s4.cls == fc_nan) || (s4.cls == fc_denorm);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fixed_value <= '0;
            flags       <= '0;
        end else if (en) begin
            case (s4.act)
                act_clear: begin
                    fixed_value <= '0;
                end
                act_saturate: begin
                    fixed_value <= s4.sign ? MIN_VAL : MAX_VAL;
                end
                default: begin    // act_pass
                    if (!s4.sign && signed_val.int_part[INT_W-1]) begin
                        fixed_value <= MAX_VAL;    // rounding carried into sign bit
                    end else begin
                        fixed_value <= signed_val;
                    end
                end
            endcase

            flags.nan      <= s4.cls == fc_nan;
            flags.infinity <= s4.cls == fc_inf;
            flags.denorm   <= s4.cls == fc_denorm;
            flags.zero     <= s4.cls == fc_zero;

            if (s4.cls == fc_inf) begin
                flags.overflow  <= 1'b1;
                flags.underflow <= 1'b0;
            end else if (no_range) begin
                flags.overflow  <= 1'b0;
                flags.underflow <= 1'b0;
            end else begin
                flags.overflow  <= s4.overflow;
                flags.underflow <= s4.underflow;
            end
        end
    end

endmodule

`default_nettype wire

// ==== fixed_fmt_pkg.sv ====
`default_nettype none

`include "float_to_fixed_defs.svh"

package fixed_fmt_pkg;

    // what the last stage does with the magnitude
    typedef enum logic [1:0] {
        act_pass,
        act_clear,
        act_saturate
    } result_act_e;

    typedef struct packed {
        logic overflow;
        logic underflow;
        logic nan;
        logic infinity;
        logic denorm;
        logic zero;
    } fix_flags_t;

    typedef struct packed {
        logic [`F2X_INT_WID-1:0] int_part;    // two's complement
        logic [`F2X_FRA_WID-1:0] fra_part;
    } fix_value_t;

    typedef struct packed {
        logic                                            sign;
        float_fmt_pkg::float_class_e                     cls;
        logic                                            overflow;
        logic                                            underflow;
        logic                                            exact_min;
        logic [`F2X_SHIFT_WID-`F2X_COARSE_WID-1:0]       fine_shift;
        logic [`F2X_MANT_WID+(1<<`F2X_COARSE_WID)-1:0]   mant;    // coarse shifted
    } stage1_t;

    typedef struct packed {
        logic                                   sign;
        float_fmt_pkg::float_class_e            cls;
        logic                                   overflow;
        logic                                   underflow;
        result_act_e                            act;
        logic [`F2X_INT_WID+`F2X_FRA_WID:0]     window;    // 0, int, fraction, round bit
    } stage2_t;

    typedef struct packed {
        logic                        sign;
        float_fmt_pkg::float_class_e cls;
        logic                        overflow;
        logic                        underflow;
        result_act_e                 act;
        fix_value_t                  mag;    // rounded magnitude
    } stage4_t;

endpackage

`default_nettype wire

// ==== float_fmt_pkg.sv ====
`default_nettype none

`include "float_to_fixed_defs.svh"

package float_fmt_pkg;

    // raw ieee-754 single precision word
    typedef struct packed {
        logic                     sign;
        logic [`F2X_EXP_WID-1:0]  exponent;    // biased
        logic [`F2X_MANT_WID-1:0] mantissa;    // hidden one not stored
    } float_word_t;

    // input class from exponent and mantissa
    typedef enum logic [2:0] {
        fc_normal,    // zero encoding, reset records look normal
        fc_zero,
        fc_denorm,
        fc_inf,
        fc_nan
    } float_class_e;

endpackage

`default_nettype wire

// ==== float_to_fixed.f ====
+incdir+.
float_fmt_pkg.sv
fixed_fmt_pkg.sv
f2x_classify.sv
f2x_align.sv
f2x_round.sv
f2x_sign_sat.sv
float_to_fixed.sv
float_to_fixed_asserts.sv
tb_float_to_fixed.sv

// ==== float_to_fixed.sv ====
`timescale 1ns/1ps
`default_nettype none

module float_to_fixed (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      en,
    input  float_fmt_pkg::float_word_t float_val,
    output fixed_fmt_pkg::fix_value_t fixed_value,
    output fixed_fmt_pkg::fix_flags_t flags
);
    import fixed_fmt_pkg::*;

    stage1_t s1;    // fields split, coarse shift
    stage2_t s2;    // aligned window
    stage4_t s4;    // rounded magnitude

    f2x_classify classify_inst (
        .clk       (clk),
        .rstn      (rstn),
        .en        (en),
        .float_val (float_val),
        .s1        (s1)
    );

    f2x_align align_inst (
        .clk  (clk),
        .rstn (rstn),
        .en   (en),
        .s1   (s1),
        .s2   (s2)
    );

    f2x_round round_inst (
        .clk  (clk),
        .rstn (rstn),
        .en   (en),
        .s2   (s2),
        .s4   (s4)
    );

    f2x_sign_sat sign_sat_inst (
        .clk         (clk),
        .rstn        (rstn),
        .en          (en),
        .s4          (s4),
        .fixed_value (fixed_value),
        .flags       (flags)
    );

endmodule

`default_nettype wire

// ==== float_to_fixed_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module float_to_fixed_asserts (
    input logic                      clk,
    input logic                      rstn,
    input logic                      en,
    input fixed_fmt_pkg::fix_value_t fixed_value,
    input fixed_fmt_pkg::fix_flags_t flags
);
    logic [2:0] cycles_out_of_reset;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cycles_out_of_reset <= '0;
        end else if (cycles_out_of_reset != 3'd5) begin
            cycles_out_of_reset <= cycles_out_of_reset + 3'd1;
        end
    end

    one_class_flag: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({flags.nan, flags.infinity, flags.denorm, flags.zero}))
        else $error("more than one class flag set");

    underflow_zero: assert property (@(posedge clk) disable iff (!rstn)
        flags.underflow |-> (fixed_value == '0))
        else $error("underflow with a nonzero result");

    hold_on_stall: assert property (@(posedge clk) disable iff (!rstn)
        !en |=> ($stable(fixed_value) && $stable(flags)))
        else $error("outputs changed while en was low");

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        (cycles_out_of_reset < 3'd5) |-> (flags == '0))
        else $error("flags set right after reset");

endmodule

bind float_to_fixed float_to_fixed_asserts asserts_inst (
    .clk         (clk),
    .rstn        (rstn),
    .en          (en),
    .fixed_value (fixed_value),
    .flags       (flags)
);

`default_nettype wire

// ==== float_to_fixed_defs.svh ====
`ifndef FLOAT_TO_FIXED_DEFS_SVH
`define FLOAT_TO_FIXED_DEFS_SVH

// single precision input fields
`define F2X_EXP_WID     8
`define F2X_MANT_WID    23
`define F2X_EXP_BIAS    127

// fixed point result, integer part carries the sign
`define F2X_INT_WID     16
`define F2X_FRA_WID     16

// biased shift amount and its low part done in stage 1
`define F2X_SHIFT_WID   6    // 15 + 17 positions
`define F2X_COARSE_WID  3

`endif

// ==== float_to_fixed_stimulus.txt ====
// float word, expected fixed value (int.fraction), expected flags
// flag bits from msb: overflow underflow nan infinity denorm zero
3FC00000 00018000 00
C0100000 FFFDC000 00
42C84000 00642000 00
B8D1B717 FFFFFFF9 00
40490FDB 0003243F 00
C640E400 CFC70000 00
37000000 00000001 00
B7000000 FFFFFFFF 00
3FFFFFC0 00020000 00
BFFFFFC0 FFFE0000 00
3F800020 00010000 00
3F800060 00010001 00
46FFFFFF 7FFFFF80 00
471C4000 7FFFFFFF 20
C71C4000 80000000 20
C7000000 80000000 00
C7000080 80000000 20
7F800000 7FFFFFFF 24
FF800000 80000000 24
36800000 00000000 10
00000000 00000000 01
80000000 00000000 01
80000001 00000000 02
7FC00000 00000000 08

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the float to fixed testbench with verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_float_to_fixed \
    -f float_to_fixed.f -o tb_float_to_fixed_sim || { echo "build failed"; exit 1; }

./obj_dir/tb_float_to_fixed_sim > sim.log 2>&1
sim_status=$?
cat sim.log

grep -q "test failed" sim.log && { echo "simulation reported a failure"; exit 1; }
[ "$sim_status" -eq 0 ] || { echo "simulation exited with status $sim_status"; exit 1; }
echo "simulation finished cleanly"

// ==== tb_float_to_fixed.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_float_to_fixed;
    import float_fmt_pkg::*;
    import fixed_fmt_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int MAX_VECTORS = 64;
    localparam int LATENCY     = 5;    // enabled edges from input to output

    typedef struct packed {
        logic       valid;
        fix_value_t value;
        fix_flags_t flags;
    } expect_t;

    logic        clk;
    logic        rstn;
    logic        en;
    float_word_t float_val;
    fix_value_t  fixed_value;
    fix_flags_t  flags;

    logic [31:0] stim_mem [0:3*MAX_VECTORS-1];    // word, value, flags per vector
    expect_t     pending [$];
    expect_t     oldest;
    integer      seed = 32'hed6b0225;
    int          num_vectors;
    int          next_idx;
    int          checked;
    bit          check_due;
    bit          loaded = 1'b0;

    float_to_fixed float_to_fixed_inst (
        .clk         (clk),
        .rstn        (rstn),
        .en          (en),
        .float_val   (float_val),
        .fixed_value (fixed_value),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected 0x%08h got 0x%08h", name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic load_vectors();
        int i;
        for (i = 0; i < 3 * MAX_VECTORS; i++) begin
            stim_mem[i] = '1;    // flags column never holds this
        end
        $readmemh("float_to_fixed_stimulus.txt", stim_mem);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS && stim_mem[3 * num_vectors + 2] != '1) begin
            num_vectors++;
        end
    endtask

    function automatic float_word_t vector_word(input int idx);
        if (idx < num_vectors) begin
            return stim_mem[3 * idx];
        end
        return '0;    // flush with zeros
    endfunction

    function automatic expect_t vector_entry(input int idx);
        expect_t e;
        e.valid = idx < num_vectors;
        e.value = e.valid ? stim_mem[3 * idx + 1] : '0;
        e.flags = e.valid ? stim_mem[3 * idx + 2][5:0] : '0;
        return e;
    endfunction

    initial begin : stimulus
        rstn      <= 1'b0;
        en        <= 1'b0;
        float_val <= '0;
        load_vectors();
        if (num_vectors == 0) begin
            $display("no vectors found in the stimulus file");
            $display("test failed");
            $fatal(1, "empty stimulus");
        end
        loaded   = 1'b1;
        next_idx = 0;
        checked  = 0;
        repeat (5) @(posedge clk);
        rstn      <= 1'b1;
        en        <= 1'b1;
        float_val <= vector_word(0);
        while (checked < num_vectors) begin
            @(posedge clk);
            check_due = 1'b0;
            if (en) begin    // dut takes float_val at this edge
                pending.push_back(vector_entry(next_idx));
                next_idx++;
                if (pending.size() == LATENCY) begin
                    oldest    = pending.pop_front();
                    check_due = oldest.valid;
                end
            end
            en        <= ($random(seed) & 3) != 0;    // low about one cycle in four
            float_val <= vector_word(next_idx);
            @(negedge clk);
            if (check_due) begin
                check_value("fixed_value", oldest.value, fixed_value);
                check_value("flags", {26'd0, oldest.flags}, {26'd0, flags});
                checked++;
            end
        end
        $display("test passed");
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #((num_vectors + 10) * 4 * CLK_PERIOD);
        $display("timeout, the pipeline stopped producing results");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
